// ==== Bender.yml ====
package:
  name: mcu_bridge

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/mcu_proto_pkg.sv
      - hdl/mcu_bus_pkg.sv
      - hdl/mcu_cmd_ctrl.sv
      - hdl/mcu_regs.sv
      - hdl/mem_buffer_dma.sv
      - hdl/mcu_bridge_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/wb_mem_model.sv
      - bench/tb_mcu_bridge.sv

// ==== bench/tb_mcu_bridge.sv ====
`timescale 1ns/1ps
`include "mcu_cfg.svh"

module tb_mcu_bridge;
    import mcu_proto_pkg::*;
    import mcu_bus_pkg::*;

    localparam int TABLE_ROWS = 19;
    localparam int MAX_BYTES = 18;
    localparam int TIMEOUT_CYCLES = 10 + TABLE_ROWS * 10 * 8 + 4000;
    localparam int MAX_POLLS = 40;

    localparam int ACT_NONE = 0;
    localparam int ACT_MARK = 1;            // note model write count first
    localparam int ACT_POLL = 2;            // wait until busy clears
    localparam int ACT_POLL_WR = 3;         // then compare model words
    localparam int ACT_POLL_STOP = 4;       // then check for a short burst
    localparam int ACT_PRESS = 5;           // hold the button down first

    logic clk;
    logic reset;
    link_rx_t link_rx;
    logic button;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic [`MCU_BYTE_W-1:0] tx_data;
    int write_count;

    string row_name [0:TABLE_ROWS-1];
    logic [7:0] row_bytes [0:TABLE_ROWS-1][0:MAX_BYTES-1];
    logic [7:0] row_exp [0:TABLE_ROWS-1][0:MAX_BYTES-1];
    logic [MAX_BYTES-1:0] row_chk [0:TABLE_ROWS-1];   // bytes whose response is checked
    int row_len [0:TABLE_ROWS-1];
    int row_act [0:TABLE_ROWS-1];
    int row_mbase [0:TABLE_ROWS-1];
    int row_mcnt [0:TABLE_ROWS-1];
    int n_rows;

    logic [15:0] words [0:7];
    logic [15:0] burst_words [0:7];
    int seed;
    int errors;
    int checks;
    int mark_count;
    int cycle_count;

    mcu_bridge_top UUT (
        .clk(clk),
        .reset(reset),
        .link_rx(link_rx),
        .button(button),
        .wb_rsp(wb_rsp),
        .tx_data(tx_data),
        .wb_req(wb_req)
    );

    wb_mem_model u_mem (
        .clk(clk),
        .reset(reset),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp),
        .write_count(write_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] mem_scr_word(input logic start, input logic stop,
                                                 input logic dir, input logic [9:0] len);
        return {17'd0, len, 2'b00, dir, stop, start};
    endfunction

    // ======================================================================
    // frame table
    // ======================================================================
    task automatic new_row(input string name, input logic [7:0] cmd,
                           input logic [7:0] addr, input int act);
        int i;
        for (i = 0; i < MAX_BYTES; i++) begin
            row_bytes[n_rows][i] = 8'h00;
            row_exp[n_rows][i] = 8'h00;
        end
        row_name[n_rows] = name;
        row_bytes[n_rows][0] = cmd;
        row_bytes[n_rows][1] = addr;
        row_chk[n_rows] = '0;
        row_len[n_rows] = 2;
        row_act[n_rows] = act;
        row_mbase[n_rows] = 0;
        row_mcnt[n_rows] = 0;
        n_rows++;
    endtask

    // register data goes low byte first
    task automatic add_reg_frame(input string name, input logic write, input logic [7:0] addr,
                                 input logic [31:0] value, input int act);
        int r;
        int i;
        r = n_rows;
        new_row(name, write ? CMD_REG_WRITE : CMD_REG_READ, addr, act);
        row_len[r] = 6;
        for (i = 0; i < 4; i++) begin
            if (write) begin
                row_bytes[r][2 + i] = value[8 * i +: 8];
            end else begin
                row_exp[r][2 + i] = value[8 * i +: 8];
                row_chk[r][2 + i] = 1'b1;
            end
        end
    endtask

    // buffer words go high byte first
    task automatic add_mem_frame(input string name, input logic write, input logic [7:0] addr,
                                 input int count);
        int r;
        int i;
        r = n_rows;
        new_row(name, write ? CMD_MEM_WRITE : CMD_MEM_READ, addr, ACT_NONE);
        row_len[r] = 2 + 2 * count;
        for (i = 0; i < count; i++) begin
            if (write) begin
                row_bytes[r][2 + 2 * i] = words[i][15:8];
                row_bytes[r][3 + 2 * i] = words[i][7:0];
            end else begin
                row_exp[r][2 + 2 * i] = words[i][15:8];
                row_exp[r][3 + 2 * i] = words[i][7:0];
                row_chk[r][2 + 2 * i] = 1'b1;
                row_chk[r][3 + 2 * i] = 1'b1;
            end
        end
    endtask

    task automatic build_table;
        int i;
        logic [31:0] rnd;
        logic [31:0] addr_val;
        logic [31:0] cfg_val;
        new_row("identify", CMD_IDENTIFY, 8'h00, ACT_NONE);   // second byte carries the ID
        row_exp[n_rows - 1][1] = `MCU_FPGA_ID;
        row_chk[n_rows - 1][1] = 1'b1;
        addr_val = $random(seed);
        rnd = $random(seed);
        cfg_val = rnd & 32'h0000_0FFF;
        add_reg_frame("write mem_address", 1'b1, REG_MEM_ADDRESS, addr_val, ACT_NONE);
        add_reg_frame("write cfg_scr", 1'b1, REG_CFG_SCR, cfg_val, ACT_NONE);
        add_reg_frame("read mem_address", 1'b0, REG_MEM_ADDRESS, addr_val, ACT_NONE);
        add_reg_frame("read cfg_scr", 1'b0, REG_CFG_SCR, {~button, 19'd0, cfg_val[11:0]},
                      ACT_NONE);
        add_reg_frame("read cfg_scr pressed", 1'b0, REG_CFG_SCR, {1'b0, 19'd0, cfg_val[11:0]},
                      ACT_PRESS);
        add_reg_frame("read cfg_version", 1'b0, REG_CFG_VERSION, `MCU_CFG_VERSION, ACT_NONE);
        for (i = 0; i < 8; i++) begin
            rnd = $random(seed);
            words[i] = rnd[15:0];
            burst_words[i] = rnd[15:0];
        end
        add_mem_frame("write buffer", 1'b1, 8'h00, 8);
        add_mem_frame("read buffer", 1'b0, 8'h00, 8);
        add_reg_frame("set write address", 1'b1, REG_MEM_ADDRESS, 32'h100, ACT_NONE);
        add_reg_frame("write burst", 1'b1, REG_MEM_SCR, mem_scr_word(1'b1, 1'b0, 1'b1, 10'd8),
                      ACT_POLL_WR);
        row_mbase[n_rows - 1] = 'h80;       // byte address 0x100
        row_mcnt[n_rows - 1] = 8;
        add_reg_frame("read save_count", 1'b0, REG_SAVE_COUNT, 32'd1, ACT_NONE);
        add_reg_frame("set read address", 1'b1, REG_MEM_ADDRESS, 32'h40, ACT_NONE);
        add_reg_frame("read burst", 1'b1, REG_MEM_SCR, mem_scr_word(1'b1, 1'b0, 1'b0, 10'd4),
                      ACT_POLL);
        for (i = 0; i < 4; i++) begin
            words[i] = 16'(32'h20 + i) ^ 16'hA5A5;  // model preset at words 0x20 up
        end
        add_mem_frame("read burst data", 1'b0, 8'h00, 4);
        add_reg_frame("set stop address", 1'b1, REG_MEM_ADDRESS, 32'h200, ACT_NONE);
        add_reg_frame("long burst start", 1'b1, REG_MEM_SCR,
                      mem_scr_word(1'b1, 1'b0, 1'b1, 10'd512), ACT_MARK);
        add_reg_frame("long burst stop", 1'b1, REG_MEM_SCR,
                      mem_scr_word(1'b0, 1'b1, 1'b1, 10'd512), ACT_POLL_STOP);
        row_mcnt[n_rows - 1] = 512;
        add_reg_frame("read mem_scr", 1'b0, REG_MEM_SCR,
                      mem_scr_word(1'b0, 1'b0, 1'b1, 10'd512), ACT_NONE);
    endtask

    // ======================================================================
    // link driver
    // ======================================================================
    task automatic start_frame;
        @(posedge clk);
        #1;
        link_rx.frame_start = 1'b1;
        @(posedge clk);
        #1;
        link_rx.frame_start = 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] value, output logic [7:0] resp);
        repeat (7) @(posedge clk);          // 8 cycles from byte to byte
        #1;
        link_rx.data = value;
        link_rx.data_ready = 1'b1;
        @(negedge clk);
        resp = tx_data;
        @(posedge clk);
        #1;
        link_rx.data_ready = 1'b0;
    endtask

    task automatic send_frame(input int r);
        int i;
        logic [7:0] resp;
        start_frame();
        for (i = 0; i < row_len[r]; i++) begin
            send_byte(row_bytes[r][i], resp);
            if (row_chk[r][i]) begin
                checks++;
                if (resp !== row_exp[r][i]) begin
                    errors++;
                    $display("** Error: %s byte %0d expected 0x%02h actual 0x%02h",
                             row_name[r], i, row_exp[r][i], resp);
                end
            end
        end
    endtask

    task automatic wait_idle(input string name);
        int polls;
        int i;
        logic [7:0] resp;
        logic [7:0] status;
        logic busy;
        busy = 1'b1;
        polls = 0;
        while (busy && polls < MAX_POLLS) begin
            start_frame();
            send_byte(CMD_REG_READ, resp);
            send_byte(REG_MEM_SCR, resp);
            send_byte(8'h00, status);
            for (i = 0; i < 3; i++) begin
                send_byte(8'h00, resp);
            end
            busy = status[3];
            polls++;
        end
        checks++;
        if (busy) begin
            errors++;
            $display("%s: burst engine still busy after %0d status reads", name, polls);
        end
    endtask

    task automatic check_model_words(input int r);
        int k;
        for (k = 0; k < row_mcnt[r]; k++) begin
            checks++;
            if (u_mem.mem[row_mbase[r] + k] !== burst_words[k]) begin
                errors++;
                $display("** Error: %s model word 0x%03h expected 0x%04h actual 0x%04h",
                         row_name[r], row_mbase[r] + k, burst_words[k],
                         u_mem.mem[row_mbase[r] + k]);
            end
        end
    endtask

    task automatic check_stop_count(input int r);
        int written;
        written = write_count - mark_count;
        checks++;
        if (written == 0 || written >= row_mcnt[r]) begin
            errors++;
            $display("** Error: %s words written expected 1 to %0d actual %0d",
                     row_name[r], row_mcnt[r] - 1, written);
        end
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        int r;
        reset = 1'b1;
        link_rx = '0;
        button = 1'b0;
        seed = 51824;
        errors = 0;
        checks = 0;
        n_rows = 0;
        mark_count = 0;
        build_table();
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        for (r = 0; r < n_rows; r++) begin
            if (row_act[r] == ACT_MARK) begin
                mark_count = write_count;
            end
            if (row_act[r] == ACT_PRESS) begin
                button = 1'b1;
            end
            send_frame(r);
            if (row_act[r] >= ACT_POLL && row_act[r] <= ACT_POLL_STOP) begin
                wait_idle(row_name[r]);
            end
            if (row_act[r] == ACT_POLL_WR) begin
                check_model_words(r);
            end
            if (row_act[r] == ACT_POLL_STOP) begin
                check_stop_count(r);
            end
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        errors++;
        $display("Timeout: frame table not finished after %0d cycles", cycle_count);
        $display("%0d checks, %0d errors", checks, errors);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== bench/wb_mem_model.sv ====
`timescale 1ns/1ps
`include "mcu_cfg.svh"

module wb_mem_model (
    input  logic                 clk,
    input  logic                 reset,
    input  mcu_bus_pkg::wb_req_t wb_req,
    output mcu_bus_pkg::wb_rsp_t wb_rsp,
    output int                   write_count
);
    localparam int WORDS = 1024;

    logic [`MCU_WORD_W-1:0] mem [0:WORDS-1];
    logic [1:0] wait_cnt;
    logic [9:0] word_idx;

    assign word_idx = wb_req.adr[10:1];     // byte address to word

    initial begin
        int i;
        for (i = 0; i < WORDS; i++) begin
            mem[i] = i[15:0] ^ 16'hA5A5;
        end
    end

    // ======================================================================
    // ack two cycles after stb, one ack per request
    // ======================================================================
    always @(posedge clk) begin
        if (reset) begin
            wb_rsp.ack <= 1'b0;
            wait_cnt <= 2'd0;
            write_count <= 0;
        end else begin
            wb_rsp.ack <= 1'b0;
            if (wb_req.cyc && wb_req.stb && !wb_rsp.ack) begin
                if (wait_cnt == 2'd1) begin
                    wait_cnt <= 2'd0;
                    wb_rsp.ack <= 1'b1;
                    if (wb_req.we) begin
                        if (wb_req.sel[1]) begin
                            mem[word_idx][15:8] <= wb_req.dat[15:8];   // byte lanes by sel
                        end
                        if (wb_req.sel[0]) begin
                            mem[word_idx][7:0] <= wb_req.dat[7:0];
                        end
                        write_count <= write_count + 1;
                    end else begin
                        wb_rsp.dat <= mem[word_idx];
                    end
                end else begin
                    wait_cnt <= wait_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== hdl/mcu_bridge_top.sv ====
`timescale 1ns/1ps
`include "mcu_cfg.svh"

module mcu_bridge_top (
    input  logic                    clk,
    input  logic                    reset,
    input  mcu_proto_pkg::link_rx_t link_rx,
    input  logic                    button,
    input  mcu_bus_pkg::wb_rsp_t    wb_rsp,
    output logic [`MCU_BYTE_W-1:0]  tx_data,
    output mcu_bus_pkg::wb_req_t    wb_req
);
    import mcu_bus_pkg::*;

    reg_access_t reg_acc;
    buf_access_t buf_acc;
    dma_ctrl_t dma_ctrl;
    logic [`MCU_REG_W-1:0] reg_rdata;
    logic [`MCU_WORD_W-1:0] buf_rdata;
    logic busy;
    logic burst_done;

    mcu_cmd_ctrl u_cmd_ctrl (
        .clk(clk),
        .reset(reset),
        .link_rx(link_rx),
        .reg_rdata(reg_rdata),
        .buf_rdata(buf_rdata),
        .tx_data(tx_data),
        .reg_acc(reg_acc),
        .buf_acc(buf_acc)
    );

    mcu_regs u_regs (
        .clk(clk),
        .reset(reset),
        .reg_acc(reg_acc),
        .button(button),
        .busy(busy),
        .burst_done(burst_done),
        .reg_rdata(reg_rdata),
        .dma_ctrl(dma_ctrl)
    );

    mem_buffer_dma u_buffer_dma (
        .clk(clk),
        .reset(reset),
        .buf_acc(buf_acc),
        .dma_ctrl(dma_ctrl),
        .wb_rsp(wb_rsp),
        .buf_rdata(buf_rdata),
        .wb_req(wb_req),
        .busy(busy),
        .burst_done(burst_done)
    );

endmodule

// ==== hdl/mcu_bus_pkg.sv ====
`include "mcu_cfg.svh"

package mcu_bus_pkg;

    typedef enum logic [7:0] {
        REG_MEM_ADDRESS = 8'd0,
        REG_MEM_SCR     = 8'd1,
        REG_CFG_SCR     = 8'd6,
        REG_CFG_VERSION = 8'd10,
        REG_SAVE_COUNT  = 8'd32
    } reg_addr_e;

    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [7:0]            address;
        logic [`MCU_REG_W-1:0] wdata;
    } reg_access_t;

    typedef struct packed {
        logic                   read;
        logic                   write;
        logic [`MCU_BUF_AW-1:0] index;
        logic [`MCU_WORD_W-1:0] wdata;
    } buf_access_t;

    typedef struct packed {
        logic                   start;
        logic                   stop;
        logic                   direction;  // 1 = buffer to bus
        logic [`MCU_BUF_AW:0]   length;     // in words
        logic [`MCU_ADDR_W-1:0] address;
    } dma_ctrl_t;

    // ======================================================================
    // wishbone classic, 16-bit data, byte address
    // ======================================================================
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`MCU_ADDR_W-1:0] adr;
        logic [`MCU_WORD_W-1:0] dat;
        logic [1:0]             sel;
    } wb_req_t;

    typedef struct packed {
        logic                   ack;
        logic [`MCU_WORD_W-1:0] dat;
    } wb_rsp_t;

endpackage

// ==== hdl/mcu_cmd_ctrl.sv ====
`timescale 1ns/1ps
`include "mcu_cfg.svh"

module mcu_cmd_ctrl (
    input  logic                     clk,
    input  logic                     reset,
    input  mcu_proto_pkg::link_rx_t  link_rx,
    input  logic [`MCU_REG_W-1:0]    reg_rdata,
    input  logic [`MCU_WORD_W-1:0]   buf_rdata,
    output logic [`MCU_BYTE_W-1:0]   tx_data,
    output mcu_bus_pkg::reg_access_t reg_acc,
    output mcu_bus_pkg::buf_access_t buf_acc
);
    import mcu_proto_pkg::*;

    phase_e phase;
    cmd_e cmd;
    logic [1:0] counter;                // byte position within a word
    logic [7:0] address;
    logic word_sel;                     // low bit of the buffer index

    logic reg_read;
    logic reg_write;
    logic buf_read;
    logic buf_write;
    logic [`MCU_REG_W-1:0] reg_wdata;
    logic [`MCU_WORD_W-1:0] buf_wdata;

    // ======================================================================
    // frame sequencer
    // ======================================================================
    always_ff @(posedge clk) begin
        reg_read <= 1'b0;
        reg_write <= 1'b0;
        buf_read <= 1'b0;
        buf_write <= 1'b0;

        if (reset) begin
            phase <= PHASE_CMD;
            cmd <= CMD_IDENTIFY;
            counter <= 2'd0;
        end else begin
            if (link_rx.frame_start) begin
                phase <= PHASE_CMD;
                counter <= 2'd0;
            end

            // two buffer words share one address value
            if (reg_read || reg_write || (word_sel && (buf_read || buf_write))) begin
                address <= address + 1'b1;
            end

            if (link_rx.data_ready) begin
                case (phase)
                    PHASE_CMD: begin
                        cmd <= cmd_e'(link_rx.data);
                        if (link_rx.data > CMD_IDENTIFY && link_rx.data <= CMD_MEM_WRITE) begin
                            phase <= PHASE_ADDRESS;
                        end else begin
                            phase <= PHASE_NOP;     // identify needs no address
                        end
                    end

                    PHASE_ADDRESS: begin
                        address <= link_rx.data;
                        phase <= PHASE_DATA;
                        reg_read <= (cmd == CMD_REG_READ);
                        buf_read <= (cmd == CMD_MEM_READ);
                        word_sel <= 1'b0;
                    end

                    PHASE_DATA: begin
                        counter <= counter + 1'b1;
                        case (cmd)
                            CMD_REG_READ: begin
                                reg_read <= (counter == 2'd3);  // prefetch next register
                            end
                            CMD_REG_WRITE: begin
                                reg_wdata[{counter, 3'b000} +: 8] <= link_rx.data;
                                reg_write <= (counter == 2'd3);
                            end
                            CMD_MEM_READ: begin
                                if (counter[0]) begin
                                    buf_read <= 1'b1;
                                    word_sel <= ~word_sel;
                                end
                            end
                            CMD_MEM_WRITE: begin
                                if (counter[0]) begin
                                    buf_wdata[7:0] <= link_rx.data;
                                    buf_write <= 1'b1;
                                    word_sel <= counter[1];
                                end else begin
                                    buf_wdata[15:8] <= link_rx.data;
                                end
                            end
                            default: ;
                        endcase
                    end

                    default: ;
                endcase
            end
        end
    end

    // response byte for the next exchange
    always_comb begin
        case (cmd)
            CMD_IDENTIFY: tx_data = `MCU_FPGA_ID;
            CMD_REG_READ: tx_data = reg_rdata[{counter, 3'b000} +: 8];
            CMD_MEM_READ: tx_data = counter[0] ? buf_rdata[7:0] : buf_rdata[15:8];
            default:      tx_data = '0;
        endcase
    end

    assign reg_acc = '{read: reg_read, write: reg_write, address: address, wdata: reg_wdata};
    assign buf_acc = '{read: buf_read, write: buf_write, index: {address, word_sel},
                       wdata: buf_wdata};

    a_reg_rw_excl: assert property (@(posedge clk) disable iff (reset)
        !(reg_acc.read && reg_acc.write));

endmodule

// ==== hdl/mcu_proto_pkg.sv ====
`include "mcu_cfg.svh"

package mcu_proto_pkg;

    // first byte of every frame
    typedef enum logic [7:0] {
        CMD_IDENTIFY  = 8'd0,
        CMD_REG_READ  = 8'd1,
        CMD_REG_WRITE = 8'd2,
        CMD_MEM_READ  = 8'd3,
        CMD_MEM_WRITE = 8'd4
    } cmd_e;

    typedef enum logic [1:0] {
        PHASE_CMD,
        PHASE_ADDRESS,
        PHASE_DATA,
        PHASE_NOP      // rest of frame ignored
    } phase_e;

    // byte stream from the link, both flags are one-cycle pulses
    typedef struct packed {
        logic                   frame_start;
        logic                   data_ready;
        logic [`MCU_BYTE_W-1:0] data;
    } link_rx_t;

endpackage

// ==== hdl/mcu_regs.sv ====
`timescale 1ns/1ps
`include "mcu_cfg.svh"

module mcu_regs (
    input  logic                     clk,
    input  logic                     reset,
    input  mcu_bus_pkg::reg_access_t reg_acc,
    input  logic                     button,
    input  logic                     busy,
    input  logic                     burst_done,
    output logic [`MCU_REG_W-1:0]    reg_rdata,
    output mcu_bus_pkg::dma_ctrl_t   dma_ctrl
);
    import mcu_bus_pkg::*;

    logic [2:0] button_ff;
    logic [`MCU_ADDR_W-1:0] mem_address;
    logic [`MCU_BUF_AW:0] mem_length;
    logic mem_direction;
    logic mem_start;
    logic mem_stop;
    logic [11:0] cfg_bits;              // bit 0 bootloader_enabled, bit 1 bootloader_skip
    logic [15:0] save_count;

    always_ff @(posedge clk) begin
        button_ff <= {button_ff[1:0], button};
    end

    // ======================================================================
    // register writes
    // ======================================================================
    always_ff @(posedge clk) begin
        mem_start <= 1'b0;
        mem_stop <= 1'b0;

        if (reset) begin
            cfg_bits <= 12'h001;
            save_count <= 16'd0;
        end else begin
            if (burst_done && mem_direction) begin
                save_count <= save_count + 1'b1;   // completed bus writes only
            end

            if (reg_acc.write) begin
                case (reg_acc.address)
                    REG_MEM_ADDRESS: mem_address <= reg_acc.wdata;
                    REG_MEM_SCR: begin
                        mem_length <= reg_acc.wdata[14:5];
                        mem_direction <= reg_acc.wdata[2];
                        mem_stop <= reg_acc.wdata[1];
                        mem_start <= reg_acc.wdata[0];
                    end
                    REG_CFG_SCR: cfg_bits <= reg_acc.wdata[11:0];
                    default: ;
                endcase
            end
        end
    end

    // read data registered one cycle after the strobe
    always_ff @(posedge clk) begin
        if (reg_acc.read) begin
            case (reg_acc.address)
                REG_MEM_ADDRESS: reg_rdata <= mem_address;
                REG_MEM_SCR:     reg_rdata <= {17'd0, mem_length, 1'b0, busy, mem_direction, 2'b00};
                REG_CFG_SCR:     reg_rdata <= {~button_ff[2], 19'd0, cfg_bits};
                REG_CFG_VERSION: reg_rdata <= `MCU_CFG_VERSION;
                REG_SAVE_COUNT:  reg_rdata <= {16'd0, save_count};
                default:         reg_rdata <= '0;
            endcase
        end
    end

    assign dma_ctrl = '{start: mem_start, stop: mem_stop, direction: mem_direction,
                        length: mem_length, address: mem_address};

endmodule

// ==== hdl/mem_buffer_dma.sv ====
`timescale 1ns/1ps
`include "mcu_cfg.svh"

module mem_buffer_dma (
    input  logic                     clk,
    input  logic                     reset,
    input  mcu_bus_pkg::buf_access_t buf_acc,
    input  mcu_bus_pkg::dma_ctrl_t   dma_ctrl,
    input  mcu_bus_pkg::wb_rsp_t     wb_rsp,
    output logic [`MCU_WORD_W-1:0]   buf_rdata,
    output mcu_bus_pkg::wb_req_t     wb_req,
    output logic                     busy,
    output logic                     burst_done
);

    logic [`MCU_WORD_W-1:0] buffer [0:`MCU_BUF_WORDS-1];

    logic [`MCU_BUF_AW:0] word_cnt;
    logic [`MCU_BUF_AW:0] length;
    logic [`MCU_BUF_AW-1:0] word_idx;
    logic direction;
    logic stop_pending;
    logic cyc;
    logic stb;
    logic [`MCU_ADDR_W-1:0] adr;
    logic [`MCU_WORD_W-1:0] wdata;
    logic last_word;

    assign word_idx = word_cnt[`MCU_BUF_AW-1:0];
    assign last_word = (word_cnt == length - 1'b1);

    // ======================================================================
    // transfer buffer, MCU port plus the bus-read fill
    // ======================================================================
    always_ff @(posedge clk) begin
        if (buf_acc.read) begin
            buf_rdata <= buffer[buf_acc.index];
        end
        if (buf_acc.write) begin
            buffer[buf_acc.index] <= buf_acc.wdata;
        end
        if (cyc && wb_rsp.ack && !direction) begin
            buffer[word_idx] <= wb_rsp.dat;
        end
    end

    // ======================================================================
    // burst engine
    // ======================================================================
    always_ff @(posedge clk) begin
        burst_done <= 1'b0;

        if (reset) begin
            busy <= 1'b0;
            stop_pending <= 1'b0;
            cyc <= 1'b0;
            stb <= 1'b0;
        end else begin
            if (dma_ctrl.stop) begin
                stop_pending <= busy;
            end else if (dma_ctrl.start && !busy && dma_ctrl.length != '0) begin
                busy <= 1'b1;
                direction <= dma_ctrl.direction;
                length <= dma_ctrl.length;
                adr <= dma_ctrl.address;
                word_cnt <= '0;
            end

            if (busy) begin
                if (!cyc) begin
                    cyc <= 1'b1;
                    stb <= 1'b1;
                    wdata <= buffer[word_idx];
                end else if (wb_rsp.ack) begin
                    cyc <= 1'b0;                    // one idle cycle per word
                    stb <= 1'b0;
                    adr <= adr + 2'd2;
                    word_cnt <= word_cnt + 1'b1;
                    if (last_word || stop_pending || dma_ctrl.stop) begin
                        busy <= 1'b0;
                        stop_pending <= 1'b0;
                        burst_done <= 1'b1;
                    end
                end
            end
        end
    end

    assign wb_req = '{cyc: cyc, stb: stb, we: direction, adr: adr, dat: wdata, sel: 2'b11};

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
        wb_req.stb |-> wb_req.cyc);

endmodule

// ==== include/mcu_cfg.svh ====
`ifndef MCU_CFG_SVH
`define MCU_CFG_SVH

// ==========================================================================
// link and register widths
// ==========================================================================
`define MCU_BYTE_W      8
`define MCU_REG_W       32

// ==========================================================================
// transfer buffer and memory bus
// ==========================================================================
`define MCU_WORD_W      16
`define MCU_BUF_WORDS   512
`define MCU_BUF_AW      9
`define MCU_ADDR_W      32

// constants returned to the MCU
`define MCU_FPGA_ID     8'h64
`define MCU_CFG_VERSION 32'h4D424731

`endif

// ==== src.f ====
+incdir+include
hdl/mcu_proto_pkg.sv
hdl/mcu_bus_pkg.sv
hdl/mcu_cmd_ctrl.sv
hdl/mcu_regs.sv
hdl/mem_buffer_dma.sv
hdl/mcu_bridge_top.sv
bench/wb_mem_model.sv
bench/tb_mcu_bridge.sv
